/* source/rtu_config.svh */
`ifndef RTU_CONFIG_SVH
`define RTU_CONFIG_SVH

// fixed-point widths for the ray/triangle datapath

`define RTU_CW 16 // input coordinate component
`define RTU_EW 17 // edge and tvec component, one bit of growth from the subtract
`define RTU_NW 36 // cross product component
`define RTU_DW 56 // det and barycentric numerators
`define RTU_FB 16 // fraction bits kept in the ray parameter t
`define RTU_PW 32 // intersection point component

`endif

/* source/rtuPkg.sv */
`include "rtu_config.svh"

package rtuPkg;

  typedef struct packed {
    logic signed [`RTU_CW-1:0] x;
    logic signed [`RTU_CW-1:0] y;
    logic signed [`RTU_CW-1:0] z;
  } coordVec; // vertex, origin or direction

  typedef struct packed {
    logic signed [`RTU_EW-1:0] x;
    logic signed [`RTU_EW-1:0] y;
    logic signed [`RTU_EW-1:0] z;
  } edgeVec; // edge, tvec or widened direction

  typedef struct packed {
    logic signed [`RTU_NW-1:0] x;
    logic signed [`RTU_NW-1:0] y;
    logic signed [`RTU_NW-1:0] z;
  } crossVec; // pvec, qvec or surface normal

  typedef struct packed {
    logic signed [`RTU_PW-1:0] x;
    logic signed [`RTU_PW-1:0] y;
    logic signed [`RTU_PW-1:0] z;
  } pointVec; // intersection point

  typedef enum logic [2:0] {
    IDLE,
    LAUNCH,
    COLLECT,
    DIVIDE,
    SCALE,
    RESPOND
  } resolveState;

  // a - b with sign extension into the edge width
  function automatic edgeVec subVec(input coordVec a, input coordVec b);
    edgeVec r;
    r.x = a.x - b.x;
    r.y = a.y - b.y;
    r.z = a.z - b.z;
    return r;
  endfunction

  function automatic edgeVec widen(input coordVec a);
    edgeVec r;
    r.x = a.x; // sign extends
    r.y = a.y;
    r.z = a.z;
    return r;
  endfunction

  function automatic crossVec crossProd(input edgeVec a, input edgeVec b);
    crossVec r;
    r.x = a.y * b.z - a.z * b.y; // products formed at full cross width
    r.y = a.z * b.x - a.x * b.z;
    r.z = a.x * b.y - a.y * b.x;
    return r;
  endfunction

  function automatic logic signed [`RTU_DW-1:0] dotProd(input edgeVec a, input crossVec b);
    return a.x * b.x + a.y * b.y + a.z * b.z;
  endfunction

endpackage

/* source/rayJobIf.sv */
`timescale 1ns/1ns

// one launched job, shared by both compute paths
interface rayJobIf import rtuPkg::*; ();

  logic    start; // single-cycle launch strobe
  coordVec v0;    // geometry held from start until next launch
  coordVec v1;
  coordVec v2;
  coordVec orig;
  coordVec dir;

  modport launcher (
    output start,
    output v0,
    output v1,
    output v2,
    output orig,
    output dir
  );

  modport worker (
    input start,
    input v0,
    input v1,
    input v2,
    input orig,
    input dir
  );

endinterface

/* source/baryIf.sv */
`timescale 1ns/1ns
`include "rtu_config.svh"

interface baryIf ();

  logic                     valid; // one-cycle pulse
  logic signed [`RTU_DW-1:0] det;   // values held until next valid
  logic signed [`RTU_DW-1:0] uNum;
  logic signed [`RTU_DW-1:0] vNum;
  logic signed [`RTU_DW-1:0] tNum;

  modport producer (
    output valid,
    output det,
    output uNum,
    output vNum,
    output tNum
  );

  modport consumer (
    input valid,
    input det,
    input uNum,
    input vNum,
    input tNum
  );

endinterface

/* source/baryTerms.sv */
`timescale 1ns/1ns

module baryTerms import rtuPkg::*; (
  input logic      clk,
  input logic      rst,
  rayJobIf.worker  job,
  baryIf.producer  bary
);

  logic [2:0] vPipe; // start travelling through the three stages

  // stage 1 registers
  edgeVec e1S1;   // v1 - v0
  edgeVec e2S1;   // v2 - v0
  edgeVec tvecS1; // orig - v0
  edgeVec dirS1;  // direction widened to edge width

  // stage 2 registers
  edgeVec  e1S2;
  edgeVec  e2S2;
  edgeVec  tvecS2;
  edgeVec  dirS2;
  crossVec pvecS2; // dir x e2
  crossVec qvecS2; // tvec x e1

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      vPipe <= '0;
    end else begin
      vPipe <= {vPipe[1:0], job.start}; // a new start may enter every cycle
    end
  end

  always_ff @(posedge clk) begin
    if (job.start) begin
      e1S1   <= subVec(job.v1, job.v0);
      e2S1   <= subVec(job.v2, job.v0);
      tvecS1 <= subVec(job.orig, job.v0);
      dirS1  <= widen(job.dir);
    end
    if (vPipe[0]) begin
      pvecS2 <= crossProd(dirS1, e2S1);
      qvecS2 <= crossProd(tvecS1, e1S1);
      e1S2   <= e1S1; // operands carried along for the dot products
      e2S2   <= e2S1;
      tvecS2 <= tvecS1;
      dirS2  <= dirS1;
    end
    if (vPipe[1]) begin
      bary.det  <= dotProd(e1S2, pvecS2);   // e1 . pvec
      bary.uNum <= dotProd(tvecS2, pvecS2); // tvec . pvec
      bary.vNum <= dotProd(dirS2, qvecS2);  // dir . qvec
      bary.tNum <= dotProd(e2S2, qvecS2);   // e2 . qvec
    end
  end

  assign bary.valid = vPipe[2]; // lands 3 cycles after start

endmodule

/* source/surfaceNormal.sv */
`timescale 1ns/1ns

module surfaceNormal import rtuPkg::*; (
  input  logic     clk,
  input  logic     rst,
  rayJobIf.worker  job,
  output logic     normValid,
  output crossVec  norm
);

  logic [1:0] vPipe; // valid for edge stage and cross stage
  edgeVec     e1;    // own copy of the edges, independent of baryTerms
  edgeVec     e2;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      vPipe <= '0;
    end else begin
      vPipe <= {vPipe[0], job.start};
    end
  end

  always_ff @(posedge clk) begin
    if (job.start) begin
      e1 <= subVec(job.v1, job.v0);
      e2 <= subVec(job.v2, job.v0);
    end
    if (vPipe[0]) begin
      norm <= crossProd(e1, e2); // unnormalized, held until next job
    end
  end

  assign normValid = vPipe[1]; // 2 cycles after start, ahead of the bary terms

endmodule

/* source/hitResolver.sv */
`timescale 1ns/1ns
`include "rtu_config.svh"

module hitResolver import rtuPkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      req,
  input  coordVec   v0,
  input  coordVec   v1,
  input  coordVec   v2,
  input  coordVec   orig,
  input  coordVec   dir,
  rayJobIf.launcher job,
  baryIf.consumer   bary,
  input  logic      normValid,
  input  crossVec   normIn,
  output logic      ack,
  output logic      hit,
  output pointVec   point,
  output crossVec   norm
);

  localparam int cntW = $clog2(`RTU_DW);
  localparam logic [cntW-1:0] lastStep = cntW'(`RTU_DW - 1); // one quotient bit per step

  resolveState state;
  logic        gotBary;   // bary terms latched for this job
  logic        gotNorm;   // normal latched for this job
  logic        bothIn;
  logic        hitNow;    // hit rule on the latched terms
  logic [cntW-1:0] divCnt;

  logic signed [`RTU_DW-1:0] detL; // raw terms as delivered
  logic signed [`RTU_DW-1:0] uL;
  logic signed [`RTU_DW-1:0] vL;
  logic signed [`RTU_DW-1:0] tL;
  logic signed [`RTU_DW-1:0] detN; // terms with det forced positive
  logic signed [`RTU_DW-1:0] uN;
  logic signed [`RTU_DW-1:0] vN;
  logic signed [`RTU_DW-1:0] tN;
  logic signed [`RTU_DW:0]   uvSum; // one bit wider so u + v cannot wrap

  logic [`RTU_DW-1:0] divRem;   // partial remainder, always below det
  logic [`RTU_DW-1:0] divQuo;   // dividend bits shift out, quotient bits shift in
  logic [`RTU_DW:0]   divTrial; // shifted remainder minus det, msb is the borrow

  // orig + (dir * tQ) >>> FB, cut to the point width
  function automatic logic signed [`RTU_PW-1:0] scaleAxis(
    input logic signed [`RTU_CW-1:0] o,
    input logic signed [`RTU_CW-1:0] d,
    input logic [`RTU_DW-1:0]        q
  );
    logic signed [`RTU_CW+`RTU_DW:0] prod;
    logic signed [`RTU_CW+`RTU_DW:0] sum;
    prod = d * $signed({1'b0, q}); // tQ is never negative
    sum  = (prod >>> `RTU_FB) + o;
    return sum[`RTU_PW-1:0];
  endfunction

  // flip all four terms together when the triangle faces away
  assign detN = detL[`RTU_DW-1] ? -detL : detL;
  assign uN   = detL[`RTU_DW-1] ? -uL : uL;
  assign vN   = detL[`RTU_DW-1] ? -vL : vL;
  assign tN   = detL[`RTU_DW-1] ? -tL : tL;

  assign uvSum  = uN + vN;
  assign hitNow = (detN != '0) && !uN[`RTU_DW-1] && !vN[`RTU_DW-1] &&
                  !tN[`RTU_DW-1] && (uvSum <= detN); // edges and vertices count
  assign bothIn = gotBary && gotNorm;

  assign divTrial = {divRem, divQuo[`RTU_DW-1]} - {1'b0, detN};

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state     <= IDLE;
      job.start <= 1'b0;
      ack       <= 1'b0;
      hit       <= 1'b0;
      gotBary   <= 1'b0;
      gotNorm   <= 1'b0;
      divCnt    <= '0;
    end else begin
      job.start <= 1'b0; // strobe lasts one cycle
      case (state)
        IDLE: begin
          if (req) begin // req is low whenever we re-enter IDLE, so this is a new job
            job.start <= 1'b1;
            gotBary   <= 1'b0;
            gotNorm   <= 1'b0;
            state     <= LAUNCH;
          end
        end
        LAUNCH: state <= COLLECT;
        COLLECT: begin
          if (bary.valid) gotBary <= 1'b1;
          if (normValid) gotNorm <= 1'b1;
          if (bothIn) begin
            hit    <= hitNow;
            divCnt <= '0;
            if (hitNow) begin
              state <= DIVIDE;
            end else begin
              ack   <= 1'b1; // miss skips the divider
              state <= RESPOND;
            end
          end
        end
        DIVIDE: begin
          divCnt <= divCnt + 1'b1;
          if (divCnt == lastStep) state <= SCALE;
        end
        SCALE: begin
          ack   <= 1'b1;
          state <= RESPOND;
        end
        RESPOND: begin
          if (!req) begin // results hold while req stays up
            ack   <= 1'b0;
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      IDLE: begin
        if (req) begin
          job.v0   <= v0; // captured job, also read back for scaling
          job.v1   <= v1;
          job.v2   <= v2;
          job.orig <= orig;
          job.dir  <= dir;
        end
      end
      COLLECT: begin
        if (bary.valid) begin
          detL <= bary.det;
          uL   <= bary.uNum;
          vL   <= bary.vNum;
          tL   <= bary.tNum;
        end
        if (normValid) norm <= normIn;
        if (bothIn) begin
          // top FB bits of tNum preload the remainder, quotient assumed under 2^DW
          divRem <= {{(`RTU_DW-`RTU_FB){1'b0}}, tN[`RTU_DW-1:`RTU_DW-`RTU_FB]};
          divQuo <= {tN[`RTU_DW-`RTU_FB-1:0], {`RTU_FB{1'b0}}};
          if (!hitNow) point <= '0;
        end
      end
      DIVIDE: begin
        if (!divTrial[`RTU_DW]) begin // det fits, keep the difference
          divRem <= divTrial[`RTU_DW-1:0];
          divQuo <= {divQuo[`RTU_DW-2:0], 1'b1};
        end else begin
          divRem <= {divRem[`RTU_DW-2:0], divQuo[`RTU_DW-1]};
          divQuo <= {divQuo[`RTU_DW-2:0], 1'b0};
        end
      end
      SCALE: begin
        point.x <= scaleAxis(job.orig.x, job.dir.x, divQuo); // divQuo now holds tQ
        point.y <= scaleAxis(job.orig.y, job.dir.y, divQuo);
        point.z <= scaleAxis(job.orig.z, job.dir.z, divQuo);
      end
      default: ;
    endcase
  end

endmodule

/* source/rayTriUnit.sv */
`timescale 1ns/1ns

module rayTriUnit import rtuPkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    req,
  input  coordVec v0,
  input  coordVec v1,
  input  coordVec v2,
  input  coordVec orig,
  input  coordVec dir,
  output logic    ack,
  output logic    hit,
  output pointVec point,
  output crossVec norm
);

  rayJobIf jobBus ();  // resolver to both paths
  baryIf   baryBus (); // barycentric terms back to the resolver

  logic    normValid;
  crossVec normPath;   // normal before the resolver latches it

  baryTerms baryTerms_i (
    .clk  (clk),
    .rst  (rst),
    .job  (jobBus.worker),
    .bary (baryBus.producer)
  );

  surfaceNormal surfaceNormal_i (
    .clk       (clk),
    .rst       (rst),
    .job       (jobBus.worker),
    .normValid (normValid),
    .norm      (normPath)
  );

  hitResolver hitResolver_i (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .v0        (v0),
    .v1        (v1),
    .v2        (v2),
    .orig      (orig),
    .dir       (dir),
    .job       (jobBus.launcher),
    .bary      (baryBus.consumer),
    .normValid (normValid),
    .normIn    (normPath),
    .ack       (ack),
    .hit       (hit),
    .point     (point),
    .norm      (norm)
  );

endmodule

/* tb/rayTriUnit_props.sv */
`timescale 1ns/1ns

module rayTriUnit_props (
  input logic clk,
  input logic rst,
  input logic req,
  input logic ack,
  input logic start
);

  int failCount = 0; // assertions that fired over the run

  ackRiseNeedsReq: assert property (@(posedge clk) disable iff (rst)
    $rose(ack) |-> $past(req)) // no answer without a request
    else begin
      $error("ack rose while req was low");
      failCount++;
    end

  ackHoldsWithReq: assert property (@(posedge clk) disable iff (rst)
    (ack && req) |=> ack) // four-phase, ack waits for req to drop
    else begin
      $error("ack fell while req was still high");
      failCount++;
    end

  startOneCycle: assert property (@(posedge clk) disable iff (rst)
    start |=> !start)
    else begin
      $error("start held for more than one cycle");
      failCount++;
    end

  ackLowInReset: assert property (@(posedge clk) rst |-> !ack)
    else begin
      $error("ack high during reset");
      failCount++;
    end

endmodule

bind hitResolver rayTriUnit_props props_i (
  .clk   (clk),
  .rst   (rst),
  .req   (req),
  .ack   (ack),
  .start (job.start)
);

/* tb/rayTriUnit_tb.sv */
`timescale 1ns/1ns
`include "rtu_config.svh"

module rayTriUnit_tb import rtuPkg::*; ();

  localparam int rowLen = 23; // fields per vector line

  logic    clk;
  logic    rst;
  logic    req;
  coordVec v0;
  coordVec v1;
  coordVec v2;
  coordVec orig;
  coordVec dir;
  logic    ack;
  logic    hit;
  pointVec point;
  crossVec norm;

  int     vals[$];              // every vector field, row after row
  int     errCount = 0;         // wrong checks over the run
  int     cycles = 0;
  int     limit = 50;           // raised once the vectors are loaded
  integer seed = 32'hefde_a7e6; // idle gap generator
  logic   testBad;

  rayTriUnit dut_i (
    .clk   (clk),
    .rst   (rst),
    .req   (req),
    .v0    (v0),
    .v1    (v1),
    .v2    (v2),
    .orig  (orig),
    .dir   (dir),
    .ack   (ack),
    .hit   (hit),
    .point (point),
    .norm  (norm)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk; // 8 ns period
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= limit) begin
      $display("timeout: the run did not finish within %0d cycles", limit);
      $display("Test failed");
      $finish;
    end
  end

  function automatic coordVec mkCoord(input int x, input int y, input int z);
    coordVec c;
    c.x = `RTU_CW'(x);
    c.y = `RTU_CW'(y);
    c.z = `RTU_CW'(z);
    return c;
  endfunction

  function automatic pointVec mkPoint(input int x, input int y, input int z);
    pointVec p;
    p.x = x;
    p.y = y;
    p.z = z;
    return p;
  endfunction

  function automatic crossVec mkNorm(input int x, input int y, input int z);
    crossVec n;
    n.x = `RTU_NW'(x); // sign extends
    n.y = `RTU_NW'(y);
    n.z = `RTU_NW'(z);
    return n;
  endfunction

  task automatic checkHit(input string name, input logic expV, input logic actV);
    if (actV !== expV) begin
      $display("ERROR %0t %s expected %0b got %0b", $time, name, expV, actV);
      errCount++;
      testBad = 1'b1;
    end
  endtask

  task automatic checkPoint(input string name, input pointVec expV, input pointVec actV);
    if (actV !== expV) begin
      $display("ERROR %0t %s expected (%0d,%0d,%0d) got (%0d,%0d,%0d)", $time, name,
               expV.x, expV.y, expV.z, actV.x, actV.y, actV.z);
      errCount++;
      testBad = 1'b1;
    end
  endtask

  task automatic checkNorm(input string name, input crossVec expV, input crossVec actV);
    if (actV !== expV) begin
      $display("ERROR %0t %s expected (%0d,%0d,%0d) got (%0d,%0d,%0d)", $time, name,
               expV.x, expV.y, expV.z, actV.x, actV.y, actV.z);
      errCount++;
      testBad = 1'b1;
    end
  endtask

  // expected columns start at base+16
  task automatic checkResults(input int base);
    checkHit("hit", vals[base+16] != 0, hit);
    checkPoint("point", mkPoint(vals[base+17], vals[base+18], vals[base+19]), point);
    checkNorm("norm", mkNorm(vals[base+20], vals[base+21], vals[base+22]), norm);
  endtask

  initial begin
    int    fd;
    int    n;
    int    r[rowLen];
    string line;
    int    base;
    int    gap;
    rst  = 1'b1;
    req  = 1'b0;
    v0   = '0;
    v1   = '0;
    v2   = '0;
    orig = '0;
    dir  = '0;
    fd = $fopen("tb/rtu_vectors.txt", "r");
    if (fd == 0) begin
      $display("could not open the vector file tb/rtu_vectors.txt");
      $display("Test failed");
      $finish;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0 && line.getc(0) != "#") begin // skip the column notes
        n = $sscanf(line,
          "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
          r[0], r[1], r[2], r[3], r[4], r[5], r[6], r[7], r[8], r[9], r[10], r[11],
          r[12], r[13], r[14], r[15], r[16], r[17], r[18], r[19], r[20], r[21], r[22]);
        if (n == rowLen) begin
          foreach (r[i]) vals.push_back(r[i]);
        end
      end
    end
    $fclose(fd);
    limit = 80 * (vals.size() / rowLen) + 50; // worst case hit plus hold and gap
    if (vals.size() == 0) begin
      $display("no test vectors were read");
      errCount++;
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int k = 0; k < vals.size() / rowLen; k++) begin
      base = k * rowLen;
      gap  = $unsigned($random(seed)) % 4; // 0 gives a req right after ack fell
      repeat (gap) @(negedge clk);
      v0   = mkCoord(vals[base], vals[base+1], vals[base+2]);
      v1   = mkCoord(vals[base+3], vals[base+4], vals[base+5]);
      v2   = mkCoord(vals[base+6], vals[base+7], vals[base+8]);
      orig = mkCoord(vals[base+9], vals[base+10], vals[base+11]);
      dir  = mkCoord(vals[base+12], vals[base+13], vals[base+14]);
      req  = 1'b1;
      testBad = 1'b0;
      do @(negedge clk); while (!ack); // latency depends on hit or miss
      checkResults(base);
      repeat (vals[base+15]) begin // back-pressure, results must hold
        @(negedge clk);
        if (!ack) begin
          $display("ack dropped at %0t while req was still high", $time);
          errCount++;
          testBad = 1'b1;
        end
        checkResults(base);
      end
      req = 1'b0;
      do @(negedge clk); while (ack);
      $display("test %0d: hit=%0b %s", k, hit, testBad ? "mismatch" : "ok");
    end
    errCount += dut_i.hitResolver_i.props_i.failCount; // handshake assertions that fired
    $display("%0d tests run, %0d wrong checks", vals.size() / rowLen, errCount);
    if (errCount == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* src.f */
+incdir+source
source/rtuPkg.sv
source/rayJobIf.sv
source/baryIf.sv
source/baryTerms.sv
source/surfaceNormal.sv
source/hitResolver.sv
source/rayTriUnit.sv
tb/rayTriUnit_props.sv
tb/rayTriUnit_tb.sv

/* tb/rtu_vectors.txt */
# columns: v0 v1 v2 orig dir (x y z each), hold, exp hit, exp point x y z, exp norm x y z
# hold is the number of extra cycles req stays high after ack
0 0 0 16 0 0 0 16 0 4 4 10 0 0 -1 0 1 4 4 0 0 0 256
0 0 0 16 0 0 0 16 0 2 3 10 1 1 -3 3 1 5 6 0 0 0 256
0 0 0 8 0 8 0 8 8 2 2 20 0 0 -1 0 1 2 2 4 -64 -64 64
-100 -100 0 200 -100 0 -100 200 0 -20 -30 50 3 4 -5 0 1 10 10 0 0 0 90000
0 0 0 0 16 0 16 0 0 4 4 10 0 0 -1 0 1 4 4 0 0 0 -256
0 0 0 0 16 0 16 0 0 2 3 10 1 1 -3 4 1 5 6 0 0 0 -256
0 0 0 16 0 0 0 16 0 0 5 10 0 0 -1 0 1 0 5 0 0 0 256
0 0 0 16 0 0 0 16 0 16 0 10 0 0 -1 1 1 16 0 0 0 0 256
0 0 0 16 0 0 0 16 0 10 6 10 0 0 -1 0 1 10 6 0 0 0 256
0 0 0 16 0 0 0 16 0 -1 4 10 0 0 -1 0 0 0 0 0 0 0 256
0 0 0 16 0 0 0 16 0 10 7 10 0 0 -1 2 0 0 0 0 0 0 256
0 0 0 16 0 0 0 16 0 4 4 -10 0 0 -1 0 0 0 0 0 0 0 256
0 0 0 16 0 0 0 16 0 4 4 10 1 0 0 0 0 0 0 0 0 0 256
-1000 200 50 3000 -500 700 100 2500 -900 10 20 30 4000 -700 650 2 0 0 0 0 -830000 4515000 9970000
